// ==== Bender.yml ====
package:
  name: cache_fa_srrip

sources:
  - hw/cache_pkg.sv
  - hw/tag_cam.sv
  - hw/srrip_line_ctrl.sv
  - hw/cache_data_ram.sv
  - hw/word_fifo.sv
  - hw/cache_fa_srrip_ctrl.sv
  - hw/cache_top.sv
  - target: simulation
    files:
      - dv/cache_tb.sv

// ==== build.f ====
hw/cache_pkg.sv
hw/tag_cam.sv
hw/srrip_line_ctrl.sv
hw/cache_data_ram.sv
hw/word_fifo.sv
hw/cache_fa_srrip_ctrl.sv
hw/cache_top.sv
dv/cache_tb.sv

// ==== dv/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

	localparam int N_REQ     = 300;
	localparam int N_POOL    = 24;	// three tags per line, forces evictions
	localparam int CYC_LIMIT = 200 * N_REQ + 100;	// plus reset and drain
	localparam int MEM_WORDS = 2 ** cache_pkg::BW_WORD_ADDR;
	localparam logic [31:0] SEED = 32'h4df310f5;

	logic                  clock_i, resetn_i;
	logic                  core_req_i, core_rw_i, core_done_o;
	cache_pkg::word_addr_t core_addr_i;
	cache_pkg::word_t      core_wdata_i, core_rdata_o;
	logic                  mem_cmd_valid_o, mem_cmd_ready_i, mem_cmd_write_o;
	cache_pkg::word_addr_t mem_cmd_addr_o;
	logic                  mem_fill_valid_i, mem_fill_ready_o;
	cache_pkg::word_t      mem_fill_data_i;
	logic                  mem_wb_valid_o, mem_wb_ready_i;
	cache_pkg::word_t      mem_wb_data_o;
	logic                  flag_hit_o, flag_miss_o, flag_writeback_o;

	cache_top DUT (.*);

	cache_pkg::word_t mem_array [MEM_WORDS];	// backing memory
	cache_pkg::word_t golden    [MEM_WORDS];	// what each load must return

	// ----------------------------------------
	// cache model
	cache_pkg::tag_t       m_tag   [cache_pkg::N_LINES];
	logic                  m_valid [cache_pkg::N_LINES];
	logic                  m_dirty [cache_pkg::N_LINES];
	cache_pkg::rrpv_t      m_rrpv  [cache_pkg::N_LINES];
	cache_pkg::word_t      m_data  [cache_pkg::RAM_WORDS];	// {line, offset}
	cache_pkg::word_addr_t exp_wb_addr [$];	// dirty victims, oldest first
	cache_pkg::word_t      exp_wb_data [$];

	int          errors, checks, misses;
	int          read_cmds, write_cmds, wb_flags, wb_words, fill_words;
	int          mem_mode;	// 0 idle, 1 fill, 2 writeback
	logic [31:0] stim_lfsr, mem_lfsr;

	initial begin
		clock_i = 1'b0;
		forever #10 clock_i = ~clock_i;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(inout logic [31:0] state, input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_step(state);
			val   = {val[30:0], state[0]};	// one step per bit
		end
	endtask

	function automatic cache_pkg::word_t init_word(input cache_pkg::word_addr_t a);
		return {a ^ 16'hc3a5, ~a} ^ {4{a[3:0], a[15:12]}};
	endfunction

	function automatic cache_pkg::tag_t pool_tag(input int idx);
		return cache_pkg::tag_t'(idx * 613 + 77);	// spread blocks apart
	endfunction

	task automatic check_word(input string what, input cache_pkg::word_t got, exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int c0, input int e0);
		$display("test %-14s %0d checks, %0d errors", name, checks - c0, errors - e0);
	endtask

	// srrip victim, ages all lines until one is distant
	task automatic model_victim(output cache_pkg::line_t v);
		logic found;
		found = 1'b0;
		v     = '0;
		while (!found) begin
			for (int i = cache_pkg::N_LINES - 1; i >= 0; i--) begin
				if (m_rrpv[i] == cache_pkg::RRPV_MAX) begin
					found = 1'b1;
					v     = cache_pkg::line_t'(i);	// lowest index wins
				end
			end
			if (!found) begin
				for (int i = 0; i < cache_pkg::N_LINES; i++) begin
					m_rrpv[i] = m_rrpv[i] + 1'b1;
				end
			end
		end
		m_rrpv[v] = cache_pkg::RRPV_INSERT;
	endtask

	// ----------------------------------------
	// one core access, model prediction and checks
	task automatic do_access(input logic rw, input cache_pkg::word_addr_t addr,
			input cache_pkg::word_t wdata);
		cache_pkg::tag_t    tag;
		cache_pkg::offset_t off;
		cache_pkg::line_t   line;
		cache_pkg::word_t   exp_rd;
		logic               hit, wb;
		int                 cycles, n_hit, n_miss, n_wb;
		tag    = addr[cache_pkg::BW_WORD_ADDR-1:cache_pkg::BW_OFFSET];
		off    = addr[cache_pkg::BW_OFFSET-1:0];
		exp_rd = golden[addr];
		hit    = 1'b0;
		wb     = 1'b0;
		line   = '0;
		for (int i = cache_pkg::N_LINES - 1; i >= 0; i--) begin
			if (m_valid[i] && m_tag[i] == tag) begin
				hit  = 1'b1;
				line = cache_pkg::line_t'(i);
			end
		end
		if (hit) begin
			m_rrpv[line] = '0;
		end else begin
			misses++;
			model_victim(line);
			wb = m_valid[line] && m_dirty[line];
			if (wb) begin
				exp_wb_addr.push_back({m_tag[line], cache_pkg::offset_t'(0)});
				for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
					exp_wb_data.push_back(m_data[{line, cache_pkg::offset_t'(w)}]);
				end
			end
			m_tag[line]   = tag;
			m_valid[line] = 1'b1;
			m_dirty[line] = 1'b0;
			for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
				m_data[{line, cache_pkg::offset_t'(w)}] = golden[{tag, cache_pkg::offset_t'(w)}];
			end
		end
		if (rw) begin
			m_dirty[line]        = 1'b1;
			m_data[{line, off}] = wdata;
			golden[addr]         = wdata;
		end

		@(negedge clock_i);	// cycle after the previous done
		core_req_i   = 1'b1;
		core_rw_i    = rw;
		core_addr_i  = addr;
		core_wdata_i = wdata;
		cycles = 0;
		n_hit  = 0;
		n_miss = 0;
		n_wb   = 0;
		do begin
			@(negedge clock_i);
			cycles++;
			n_hit  += flag_hit_o;
			n_miss += flag_miss_o;
			n_wb   += flag_writeback_o;
		end while (!core_done_o);
		if (!rw) check_word("load data", core_rdata_o, exp_rd);
		core_req_i = 1'b0;
		check_word("hit flag pulses", n_hit, hit);
		check_word("miss flag pulses", n_miss, !hit);
		check_word("writeback flag pulses", n_wb, wb);
		if (hit) check_word("hit latency", cycles, 2);
	endtask

	// ----------------------------------------
	// memory model, serves one command at a time
	initial begin : memory_model
		cache_pkg::word_addr_t addr;
		int                    left;
		logic                  cmd_hold;	// command waited last cycle
		logic [31:0]           r;
		addr     = '0;
		left     = 0;
		cmd_hold = 1'b0;
		mem_mode = 0;
		mem_lfsr = {SEED[15:0], SEED[31:16]};	// own stream
		mem_cmd_ready_i  = 1'b0;
		mem_fill_valid_i = 1'b0;
		mem_fill_data_i  = '0;
		mem_wb_ready_i   = 1'b0;
		forever begin
			@(negedge clock_i);
			draw(mem_lfsr, 4, r);
			// new read command, every flagged writeback must be commanded already
			if (mem_cmd_valid_o && !mem_cmd_write_o && !cmd_hold) begin
				check_word("write commands before read", write_cmds, wb_flags);
			end
			if (flag_writeback_o) wb_flags++;
			mem_fill_valid_i = (mem_mode == 1) && r[2];	// random gaps
			mem_fill_data_i  = mem_array[addr];
			if (mem_fill_valid_i && mem_fill_ready_o) begin
				fill_words++;
				addr++;
				left--;
			end
			mem_wb_ready_i = (mem_mode == 2) && r[3];
			if (mem_wb_ready_i && mem_wb_valid_o) begin
				wb_words++;
				if (exp_wb_data.size() != 0) begin
					check_word("writeback word", mem_wb_data_o, exp_wb_data.pop_front());
				end
				mem_array[addr] = mem_wb_data_o;
				addr++;
				left--;
			end
			if (left == 0) mem_mode = 0;
			mem_cmd_ready_i = (mem_mode == 0) && (r[0] | r[1]);
			cmd_hold        = mem_cmd_valid_o && !mem_cmd_ready_i;
			if (mem_cmd_valid_o && mem_cmd_ready_i) begin
				addr = mem_cmd_addr_o;
				left = cache_pkg::WORDS_PER_LINE;
				if (mem_cmd_write_o) begin
					mem_mode = 2;
					write_cmds++;
					checks++;
					assert (exp_wb_addr.size() != 0) else begin
						errors++;
						$display("ERROR %0t: write command without a dirty victim", $time);
					end
					if (exp_wb_addr.size() != 0) begin
						check_word("writeback address", mem_cmd_addr_o, exp_wb_addr.pop_front());
					end
				end else begin
					mem_mode = 1;
					read_cmds++;
				end
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYC_LIMIT) begin
			@(posedge clock_i);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYC_LIMIT);
		$display("Done: errors found");
		$finish;
	end

	// ----------------------------------------
	initial begin : stimulus
		logic [31:0]           r;
		logic                  rw;
		cache_pkg::word_addr_t addr;
		int                    c0, e0;
		core_req_i   = 1'b0;
		core_rw_i    = 1'b0;
		core_addr_i  = '0;
		core_wdata_i = '0;
		resetn_i     = 1'b0;
		stim_lfsr    = SEED;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem_array[a] = init_word(cache_pkg::word_addr_t'(a));
			golden[a]    = mem_array[a];
		end
		for (int i = 0; i < cache_pkg::N_LINES; i++) begin
			m_valid[i] = 1'b0;
			m_dirty[i] = 1'b0;
			m_rrpv[i]  = cache_pkg::RRPV_MAX;
		end
		repeat (2) @(negedge clock_i);
		resetn_i = 1'b1;

		c0 = checks;
		e0 = errors;
		repeat (4) begin	// quiet until the first request
			@(negedge clock_i);
			check_word("idle outputs", {core_done_o, mem_cmd_valid_o, mem_wb_valid_o,
				flag_hit_o, flag_miss_o, flag_writeback_o}, '0);
			check_word("fill fifo ready", mem_fill_ready_o, 1'b1);
		end
		report_test("reset_idle", c0, e0);

		c0 = checks;
		e0 = errors;
		for (int n = 0; n < N_REQ; n++) begin
			draw(stim_lfsr, 1, r);
			rw = r[0];
			draw(stim_lfsr, 5, r);
			addr = {pool_tag(r % N_POOL), cache_pkg::offset_t'(0)};
			draw(stim_lfsr, 2, r);
			addr[cache_pkg::BW_OFFSET-1:0] = r[cache_pkg::BW_OFFSET-1:0];
			draw(stim_lfsr, 32, r);
			do_access(rw, addr, r);
		end
		report_test("random_access", c0, e0);

		// let the last writeback drain
		c0 = checks;
		e0 = errors;
		repeat (2) @(posedge clock_i);
		while (mem_mode != 0 || write_cmds != wb_flags) @(posedge clock_i);
		@(negedge clock_i);
		check_word("writeback fifo empty", mem_wb_valid_o, 1'b0);
		check_word("read commands", read_cmds, misses);
		check_word("fill words", fill_words, cache_pkg::WORDS_PER_LINE * read_cmds);
		check_word("writeback words", wb_words, cache_pkg::WORDS_PER_LINE * write_cmds);
		check_word("unseen dirty victims", exp_wb_addr.size(), 0);
		check_word("unseen writeback words", exp_wb_data.size(), 0);
		report_test("mem_channels", c0, e0);

		$display("tests 3, checks %0d, errors %0d, misses %0d, writebacks %0d",
			checks, errors, misses, write_cmds);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== hw/cache_data_ram.sv ====
`timescale 1ns/1ps

module cache_data_ram (
	input  logic                 clock_i,
	input  logic                 we_i,
	input  cache_pkg::ram_addr_t addr_i,	// {line, offset}
	input  cache_pkg::word_t     wdata_i,
	output cache_pkg::word_t     rdata_o
);

	cache_pkg::word_t mem_q [cache_pkg::RAM_WORDS];

	// single port, read returns old data on a write
	always_ff @(posedge clock_i) begin
		if (we_i) begin
			mem_q[addr_i] <= wdata_i;
		end
		rdata_o <= mem_q[addr_i];	// registered read
	end

endmodule

// ==== hw/cache_fa_srrip_ctrl.sv ====
`timescale 1ns/1ps

module cache_fa_srrip_ctrl (
	input  logic                  clock_i,
	input  logic                  resetn_i,
	// core
	input  logic                  core_req_i,
	input  logic                  core_rw_i,	// 1 = store
	input  cache_pkg::word_addr_t core_addr_i,
	input  cache_pkg::word_t      core_wdata_i,
	output logic                  core_done_o,
	output cache_pkg::word_t      core_rdata_o,
	// memory command
	output logic                  mem_cmd_valid_o,
	input  logic                  mem_cmd_ready_i,
	output logic                  mem_cmd_write_o,
	output cache_pkg::word_addr_t mem_cmd_addr_o,	// block start
	// fill and writeback FIFOs
	input  logic                  fill_valid_i,
	output logic                  fill_ready_o,
	input  cache_pkg::word_t      fill_data_i,
	output logic                  wb_valid_o,
	input  logic                  wb_ready_i,
	output cache_pkg::word_t      wb_data_o,
	// tag CAM
	output cache_pkg::tag_t       cam_search_tag_o,
	output logic                  cam_write_o,
	output cache_pkg::line_t      cam_line_o,
	output cache_pkg::tag_t       cam_write_tag_o,
	input  logic                  cam_hit_i,
	input  cache_pkg::line_t      cam_hit_line_i,
	input  cache_pkg::tag_t       cam_line_tag_i,
	// replacement
	output logic                  srrip_hit_o,
	output cache_pkg::line_t      srrip_hit_line_o,
	output logic                  srrip_miss_o,
	input  logic                  srrip_done_i,
	input  cache_pkg::line_t      srrip_victim_i,
	// data RAM
	output logic                  ram_we_o,
	output cache_pkg::ram_addr_t  ram_addr_o,
	output cache_pkg::word_t      ram_wdata_o,
	input  cache_pkg::word_t      ram_rdata_i,
	// performance
	output logic                  flag_hit_o,
	output logic                  flag_miss_o,
	output logic                  flag_writeback_o
);

	typedef enum logic [2:0] {
		st_lookup, st_wait_mem, st_wait_victim, st_writeback, st_refill
	} ctrl_state_e;

	ctrl_state_e                 state_q;
	logic                        busy_q, done_q;	// hit pipeline stages
	logic                        replay_q, rw_q;	// held request after a miss
	logic [cache_pkg::N_LINES-1:0] dirty_q;
	cache_pkg::line_t            line_q, victim_q, hit_line_q;
	logic                        victim_vld_q;
	cache_pkg::offset_t          cnt_q;	// word within the block
	logic                        rd_wait_q;	// RAM read in flight
	logic                        wb_pend_q;	// write command waiting for mem_cmd
	cache_pkg::word_addr_t       wb_addr_q, cmd_addr_q;
	logic                        cmd_valid_q, cmd_write_q;
	logic                        ram_we_q;
	cache_pkg::ram_addr_t        ram_addr_q;
	cache_pkg::word_t            ram_wdata_q;
	logic                        flag_hit_q, flag_miss_q, flag_wb_q;

	cache_pkg::tag_t             req_tag;
	cache_pkg::offset_t          req_offset, next_cnt;
	cache_pkg::line_t            victim_sel;
	logic                        victim_rdy, accept, rw_sel, last_word;
	logic                        fill_fire, wb_fire, cmd_free;

	assign req_tag    = core_addr_i[cache_pkg::BW_WORD_ADDR-1:cache_pkg::BW_OFFSET];
	assign req_offset = core_addr_i[cache_pkg::BW_OFFSET-1:0];
	assign victim_rdy = victim_vld_q | srrip_done_i;	// done may come early
	assign victim_sel = srrip_done_i ? srrip_victim_i : victim_q;
	assign accept     = core_req_i & ~busy_q & ~done_q & (state_q == st_lookup);
	assign rw_sel     = replay_q ? rw_q : core_rw_i;
	assign next_cnt   = cnt_q + 1'b1;
	assign last_word  = (cnt_q == cache_pkg::offset_t'(cache_pkg::WORDS_PER_LINE - 1));
	assign fill_ready_o = (state_q == st_refill);
	assign fill_fire  = fill_valid_i & fill_ready_o;
	assign wb_valid_o = (state_q == st_writeback) & ~rd_wait_q;	// rdata valid
	assign wb_data_o  = ram_rdata_i;
	assign wb_fire    = wb_valid_o & wb_ready_i;
	assign cmd_free   = ~cmd_valid_q | mem_cmd_ready_i;

	// tag written with the last fill word so the replay hits at once
	assign cam_search_tag_o = req_tag;
	assign cam_write_tag_o  = req_tag;
	assign cam_line_o       = line_q;
	assign cam_write_o      = fill_fire & last_word;

	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q      <= st_lookup;
			{busy_q, done_q, replay_q, rw_q} <= '0;
			dirty_q      <= '0;
			victim_vld_q <= 1'b0;
			cnt_q        <= '0;
			rd_wait_q    <= 1'b0;
			wb_pend_q    <= 1'b0;
			cmd_valid_q  <= 1'b0;
			ram_we_q     <= 1'b0;
			{flag_hit_q, flag_miss_q, flag_wb_q} <= '0;
		end else begin
			done_q   <= busy_q;	// RAM read lands one cycle after busy
			busy_q   <= 1'b0;
			ram_we_q <= 1'b0;
			{flag_hit_q, flag_miss_q, flag_wb_q} <= '0;
			if (cmd_valid_q && mem_cmd_ready_i) cmd_valid_q <= 1'b0;
			if (srrip_done_i) begin
				victim_vld_q <= 1'b1;
				victim_q     <= srrip_victim_i;
			end
			// pending writeback takes mem_cmd once free
			if (wb_pend_q && cmd_free) begin
				cmd_valid_q <= 1'b1;
				cmd_write_q <= 1'b1;
				cmd_addr_q  <= wb_addr_q;
				wb_pend_q   <= 1'b0;
			end
			case (state_q)
				st_lookup: if (accept) begin
					replay_q <= 1'b0;
					if (cam_hit_i) begin
						busy_q      <= 1'b1;
						ram_addr_q  <= {cam_hit_line_i, req_offset};
						ram_we_q    <= rw_sel;
						ram_wdata_q <= core_wdata_i;
						if (rw_sel) dirty_q[cam_hit_line_i] <= 1'b1;
						flag_hit_q  <= ~replay_q;	// replay is not a new access
						hit_line_q  <= cam_hit_line_i;
					end else begin
						flag_miss_q <= 1'b1;	// also starts the victim search
						rw_q        <= core_rw_i;
						state_q     <= st_wait_mem;
					end
				end
				st_wait_mem: if (!wb_pend_q && cmd_free) begin
					cmd_valid_q <= 1'b1;	// block read
					cmd_write_q <= 1'b0;
					cmd_addr_q  <= {req_tag, cache_pkg::offset_t'(0)};
					state_q     <= st_wait_victim;
				end
				st_wait_victim: if (victim_rdy) begin
					victim_vld_q        <= 1'b0;
					line_q              <= victim_sel;
					dirty_q[victim_sel] <= 1'b0;
					cnt_q               <= '0;
					if (dirty_q[victim_sel]) begin
						flag_wb_q  <= 1'b1;
						ram_addr_q <= {victim_sel, cache_pkg::offset_t'(0)};
						rd_wait_q  <= 1'b1;
						state_q    <= st_writeback;
					end else begin
						state_q <= st_refill;	// clean, just overwrite
					end
				end
				st_writeback: if (rd_wait_q) begin
					rd_wait_q <= 1'b0;
				end else if (wb_fire) begin
					if (cnt_q == '0) begin
						wb_addr_q <= {cam_line_tag_i, cache_pkg::offset_t'(0)};
						wb_pend_q <= 1'b1;	// first word is in the FIFO
					end
					cnt_q <= next_cnt;
					if (last_word) begin
						state_q <= st_refill;
					end else begin
						ram_addr_q <= {line_q, next_cnt};
						rd_wait_q  <= 1'b1;
					end
				end
				st_refill: if (fill_fire) begin
					ram_we_q    <= 1'b1;
					ram_addr_q  <= {line_q, cnt_q};
					ram_wdata_q <= fill_data_i;
					cnt_q       <= next_cnt;
					if (last_word) begin
						replay_q <= 1'b1;
						state_q  <= st_lookup;
					end
				end
				default: state_q <= st_lookup;
			endcase
		end
	end

	assign core_done_o      = done_q;
	assign core_rdata_o     = ram_rdata_i;
	assign mem_cmd_valid_o  = cmd_valid_q;
	assign mem_cmd_write_o  = cmd_write_q;
	assign mem_cmd_addr_o   = cmd_addr_q;
	assign srrip_hit_o      = flag_hit_q;
	assign srrip_hit_line_o = hit_line_q;
	assign srrip_miss_o     = flag_miss_q;
	assign ram_we_o         = ram_we_q;
	assign ram_addr_o       = ram_addr_q;
	assign ram_wdata_o      = ram_wdata_q;
	assign flag_hit_o       = flag_hit_q;
	assign flag_miss_o      = flag_miss_q;
	assign flag_writeback_o = flag_wb_q;

endmodule

// ==== hw/cache_pkg.sv ====
package cache_pkg;

	// ----------------------------------------
	// geometry
	localparam int N_LINES        = 8;
	localparam int WORDS_PER_LINE = 4;
	localparam int BW_LINE        = 3;	// log2 of N_LINES
	localparam int BW_OFFSET      = 2;	// log2 of WORDS_PER_LINE
	localparam int BW_WORD        = 32;
	localparam int BW_WORD_ADDR   = 16;
	localparam int BW_TAG         = BW_WORD_ADDR - BW_OFFSET;	// block number
	localparam int BW_RAM_ADDR    = BW_LINE + BW_OFFSET;	// {line, offset}
	localparam int RAM_WORDS      = N_LINES * WORDS_PER_LINE;

	// ----------------------------------------
	// replacement
	localparam int RRPV_BW = 2;
	localparam logic [RRPV_BW-1:0] RRPV_MAX    = {RRPV_BW{1'b1}};	// distant
	localparam logic [RRPV_BW-1:0] RRPV_INSERT = RRPV_MAX - 1'b1;	// long

	// buffering
	localparam int FIFO_DEPTH  = 4;
	localparam int BW_FIFO_PTR = 2;	// log2 of FIFO_DEPTH

	// ----------------------------------------
	// vector types
	typedef logic [BW_WORD-1:0]      word_t;
	typedef logic [BW_TAG-1:0]       tag_t;
	typedef logic [BW_LINE-1:0]      line_t;
	typedef logic [BW_OFFSET-1:0]    offset_t;
	typedef logic [BW_WORD_ADDR-1:0] word_addr_t;
	typedef logic [BW_RAM_ADDR-1:0]  ram_addr_t;
	typedef logic [RRPV_BW-1:0]      rrpv_t;

endpackage

// ==== hw/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
	input  logic                  clock_i,
	input  logic                  resetn_i,
	input  logic                  core_req_i,
	input  logic                  core_rw_i,
	input  cache_pkg::word_addr_t core_addr_i,
	input  cache_pkg::word_t      core_wdata_i,
	output logic                  core_done_o,
	output cache_pkg::word_t      core_rdata_o,
	output logic                  mem_cmd_valid_o,
	input  logic                  mem_cmd_ready_i,
	output logic                  mem_cmd_write_o,
	output cache_pkg::word_addr_t mem_cmd_addr_o,
	input  logic                  mem_fill_valid_i,
	output logic                  mem_fill_ready_o,
	input  cache_pkg::word_t      mem_fill_data_i,
	output logic                  mem_wb_valid_o,
	input  logic                  mem_wb_ready_i,
	output cache_pkg::word_t      mem_wb_data_o,
	output logic                  flag_hit_o,
	output logic                  flag_miss_o,
	output logic                  flag_writeback_o
);

	// ----------------------------------------
	logic                 fill_valid, fill_ready, wb_valid, wb_ready;
	cache_pkg::word_t     fill_data, wb_data;
	cache_pkg::tag_t      cam_search_tag, cam_write_tag, cam_line_tag;
	logic                 cam_write, cam_hit;
	cache_pkg::line_t     cam_line, cam_hit_line;
	logic                 srrip_hit, srrip_miss, srrip_done;
	cache_pkg::line_t     srrip_hit_line, srrip_victim;
	logic                 ram_we;
	cache_pkg::ram_addr_t ram_addr;
	cache_pkg::word_t     ram_wdata, ram_rdata;

	cache_fa_srrip_ctrl u_ctrl (
		.clock_i, .resetn_i,
		.core_req_i, .core_rw_i, .core_addr_i, .core_wdata_i, .core_done_o, .core_rdata_o,
		.mem_cmd_valid_o, .mem_cmd_ready_i, .mem_cmd_write_o, .mem_cmd_addr_o,
		.fill_valid_i(fill_valid), .fill_ready_o(fill_ready), .fill_data_i(fill_data),
		.wb_valid_o(wb_valid), .wb_ready_i(wb_ready), .wb_data_o(wb_data),
		.cam_search_tag_o(cam_search_tag), .cam_write_o(cam_write), .cam_line_o(cam_line),
		.cam_write_tag_o(cam_write_tag), .cam_hit_i(cam_hit), .cam_hit_line_i(cam_hit_line),
		.cam_line_tag_i(cam_line_tag),
		.srrip_hit_o(srrip_hit), .srrip_hit_line_o(srrip_hit_line), .srrip_miss_o(srrip_miss),
		.srrip_done_i(srrip_done), .srrip_victim_i(srrip_victim),
		.ram_we_o(ram_we), .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata),
		.ram_rdata_i(ram_rdata),
		.flag_hit_o, .flag_miss_o, .flag_writeback_o
	);

	tag_cam u_cam (
		.clock_i, .resetn_i,
		.search_tag_i(cam_search_tag), .write_i(cam_write), .line_i(cam_line),
		.write_tag_i(cam_write_tag), .hit_o(cam_hit), .hit_line_o(cam_hit_line),
		.line_tag_o(cam_line_tag)
	);

	srrip_line_ctrl u_srrip (
		.clock_i, .resetn_i,
		.hit_i(srrip_hit), .hit_line_i(srrip_hit_line), .miss_i(srrip_miss),
		.done_o(srrip_done), .victim_o(srrip_victim)
	);

	cache_data_ram u_ram (
		.clock_i, .we_i(ram_we), .addr_i(ram_addr), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
	);

	// memory to controller
	word_fifo u_fill_fifo (
		.clock_i, .resetn_i,
		.in_valid_i(mem_fill_valid_i), .in_ready_o(mem_fill_ready_o), .in_data_i(mem_fill_data_i),
		.out_valid_o(fill_valid), .out_ready_i(fill_ready), .out_data_o(fill_data)
	);

	// controller to memory
	word_fifo u_wb_fifo (
		.clock_i, .resetn_i,
		.in_valid_i(wb_valid), .in_ready_o(wb_ready), .in_data_i(wb_data),
		.out_valid_o(mem_wb_valid_o), .out_ready_i(mem_wb_ready_i), .out_data_o(mem_wb_data_o)
	);

endmodule

// ==== hw/srrip_line_ctrl.sv ====
`timescale 1ns/1ps

module srrip_line_ctrl (
	input  logic             clock_i,
	input  logic             resetn_i,
	input  logic             hit_i,
	input  cache_pkg::line_t hit_line_i,
	input  logic             miss_i,	// starts a victim search
	output logic             done_o,	// one cycle, victim_o valid
	output cache_pkg::line_t victim_o
);

	cache_pkg::rrpv_t rrpv_q [cache_pkg::N_LINES];
	logic             searching_q;
	logic             done_q;
	cache_pkg::line_t victim_q;

	logic             found;
	cache_pkg::line_t found_line;
	logic             search_active;

	assign search_active = miss_i | searching_q;	// miss cycle is the first try

	// lowest-index line at distant value
	always_comb begin
		found      = 1'b0;
		found_line = '0;
		for (int i = cache_pkg::N_LINES - 1; i >= 0; i--) begin
			if (rrpv_q[i] == cache_pkg::RRPV_MAX) begin
				found      = 1'b1;
				found_line = cache_pkg::line_t'(i);
			end
		end
	end

	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < cache_pkg::N_LINES; i++) begin
				rrpv_q[i] <= cache_pkg::RRPV_MAX;	// empty lines go first
			end
			searching_q <= 1'b0;
			done_q      <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (hit_i) begin
				rrpv_q[hit_line_i] <= '0;	// near re-reference
			end
			if (search_active) begin
				if (found) begin
					rrpv_q[found_line] <= cache_pkg::RRPV_INSERT;
					victim_q           <= found_line;
					done_q             <= 1'b1;
					searching_q        <= 1'b0;
				end else begin
					// age all lines, none is at max so no wrap
					for (int i = 0; i < cache_pkg::N_LINES; i++) begin
						rrpv_q[i] <= rrpv_q[i] + 1'b1;
					end
					searching_q <= 1'b1;
				end
			end
		end
	end

	assign done_o   = done_q;
	assign victim_o = victim_q;

endmodule

// ==== hw/tag_cam.sv ====
`timescale 1ns/1ps

module tag_cam (
	input  logic             clock_i,
	input  logic             resetn_i,
	input  cache_pkg::tag_t  search_tag_i,	// lookup key
	input  logic             write_i,
	input  cache_pkg::line_t line_i,	// write and readback index
	input  cache_pkg::tag_t  write_tag_i,
	output logic             hit_o,
	output cache_pkg::line_t hit_line_o,
	output cache_pkg::tag_t  line_tag_o	// tag stored at line_i
);

	cache_pkg::tag_t            tags_q [cache_pkg::N_LINES];
	logic [cache_pkg::N_LINES-1:0] valid_q;

	// tag store
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (write_i) begin
			valid_q[line_i] <= 1'b1;
		end
		if (write_i) begin
			tags_q[line_i] <= write_tag_i;	// tag payload, valid bit guards it
		end
	end

	// ----------------------------------------
	// parallel match over all valid entries
	always_comb begin
		hit_o      = 1'b0;
		hit_line_o = '0;
		// walk downward so lowest index wins
		for (int i = cache_pkg::N_LINES - 1; i >= 0; i--) begin
			if (valid_q[i] && (tags_q[i] == search_tag_i)) begin
				hit_o      = 1'b1;
				hit_line_o = cache_pkg::line_t'(i);
			end
		end
	end

	assign line_tag_o = tags_q[line_i];	// victim tag for writeback address

endmodule

// ==== hw/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo (
	input  logic             clock_i,
	input  logic             resetn_i,
	input  logic             in_valid_i,
	output logic             in_ready_o,	// low when full
	input  cache_pkg::word_t in_data_i,
	output logic             out_valid_o,	// low when empty
	input  logic             out_ready_i,
	output cache_pkg::word_t out_data_o
);

	cache_pkg::word_t                mem_q [cache_pkg::FIFO_DEPTH];
	logic [cache_pkg::BW_FIFO_PTR-1:0] wr_ptr_q;
	logic [cache_pkg::BW_FIFO_PTR-1:0] rd_ptr_q;
	logic [cache_pkg::BW_FIFO_PTR:0]   count_q;	// one bit wider, holds full

	logic push;
	logic pop;

	assign in_ready_o  = (count_q != cache_pkg::FIFO_DEPTH);
	assign out_valid_o = (count_q != '0);
	assign out_data_o  = mem_q[rd_ptr_q];	// head word
	assign push        = in_valid_i & in_ready_o;
	assign pop         = out_valid_o & out_ready_i;

	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;	// wraps, depth is a power of two
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			if (push && !pop) begin
				count_q <= count_q + 1'b1;
			end else if (pop && !push) begin
				count_q <= count_q - 1'b1;
			end
		end
		if (push) begin
			mem_q[wr_ptr_q] <= in_data_i;
		end
	end

endmodule
